// File: hdl/exp_neg.sv
`timescale 1ns/10ps

// exp(-a) = 2^(-a*log2(e)) split into integer shift k and table index j
module exp_neg (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          adv,           // pipeline enable
  input  logic [selu_pkg::IN_W-1:0]     a,             // |x| in q7.8
  output logic [selu_pkg::EXP_FRAC:0]   e              // q1.16
);

  logic [selu_pkg::T_W-1:0]                 t;         // q.24 exponent of two
  logic [selu_pkg::T_W-selu_pkg::T_FRAC-1:0] t_int;    // integer part of t
  logic [selu_pkg::K_W-1:0]                 k_next;
  logic [selu_pkg::LUT_AW-1:0]              j_next;
  logic [selu_pkg::K_W-1:0]                 k_q;       // shift, saturated
  logic [selu_pkg::LUT_AW-1:0]              j_q;       // top fraction bits of t

  assign t     = a * selu_pkg::LOG2E_Q;
  assign t_int = t[selu_pkg::T_W-1:selu_pkg::T_FRAC];

  always_comb begin
    if (t_int >= selu_pkg::EXP_K_MAX) begin
      k_next = selu_pkg::K_W'(selu_pkg::EXP_K_MAX);    // result will flush to 0
    end else begin
      k_next = t_int[selu_pkg::K_W-1:0];
    end
    j_next = t[selu_pkg::T_FRAC-1 -: selu_pkg::LUT_AW]; // lower fraction bits dropped
  end

  // range reduction stage
  always_ff @(posedge clk) begin
    if (rst) begin
      k_q <= '0;
      j_q <= '0;
    end else if (adv) begin
      k_q <= k_next;
      j_q <= j_next;
    end
  end

  // table lookup and shift stage
  always_ff @(posedge clk) begin
    if (rst) begin
      e <= '0;
    end else if (adv) begin
      if (k_q >= selu_pkg::EXP_K_MAX) begin
        e <= '0;
      end else begin
        e <= selu_pkg::EXP_LUT[j_q] >> k_q;            // no interpolation
      end
    end
  end

  a_e_range: assert property (@(posedge clk) disable iff (rst)
    e <= selu_pkg::EXP_ONE);                           // exp of a non-negative arg

endmodule

// File: hdl/fixed_round.sv
`timescale 1ns/10ps

module fixed_round #(
  parameter int IN_W     = 56,                         // wide signed input
  parameter int IN_FRAC  = 32,
  parameter int OUT_W    = 19,                         // narrowed output
  parameter int OUT_FRAC = 8
) (
  input  logic signed [IN_W-1:0]  in,
  output logic signed [OUT_W-1:0] out
);

  logic signed [IN_W:0]                  half;         // half an output lsb at input scale
  logic signed [IN_W:0]                  sum;          // guard bit takes the carry
  logic signed [IN_W-IN_FRAC+OUT_FRAC:0] trunc;        // extra fraction dropped
  logic signed [OUT_W-1:0]               narrow;
  logic                                  ovf;          // integer part does not fit

  assign half   = (IN_W + 1)'(1) << (IN_FRAC - OUT_FRAC - 1);
  assign sum    = $signed({in[IN_W-1], in}) + half;    // round half up
  assign trunc  = sum[IN_W:IN_FRAC-OUT_FRAC];          // floor after the add
  assign narrow = trunc[OUT_W-1:0];

  // any upper bit differing from the narrow sign means overflow
  assign ovf = (trunc != narrow);

  always_comb begin
    if (!ovf) begin
      out = narrow;
    end else if (trunc[IN_W-IN_FRAC+OUT_FRAC]) begin
      out = {1'b1, {(OUT_W - 1){1'b0}}};               // clamp to most negative
    end else begin
      out = {1'b0, {(OUT_W - 1){1'b1}}};               // clamp to most positive
    end
  end

endmodule

// File: hdl/selu_lane.sv
`timescale 1ns/10ps

module selu_lane (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              adv,       // hold everything when low
  input  logic signed [selu_pkg::IN_W-1:0]  x,         // q7.8
  output logic signed [selu_pkg::OUT_W-1:0] y          // rounded to OUT_FRAC bits
);

  selu_pkg::lane_stage_t                 s1_q;         // registered input
  selu_pkg::lane_stage_t                 s2_q;
  selu_pkg::lane_stage_t                 s3_q;         // lines up with e
  logic [selu_pkg::IN_W-1:0]             abs_x_q;      // exp argument
  logic [selu_pkg::EXP_FRAC:0]           e;            // exp(-|x|) in q1.16
  logic signed [selu_pkg::EXP_FRAC+1:0]  e_m1;         // exp - 1 is never positive
  logic signed [selu_pkg::PROD_W-1:0]    prod_neg;
  logic signed [selu_pkg::PROD_W-1:0]    prod_pos;
  logic signed [selu_pkg::PROD_W-1:0]    prod_q;       // q.32

  // input stage
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_q    <= '0;
      abs_x_q <= '0;
    end else if (adv) begin
      s1_q.neg <= (x <= 0);
      s1_q.x   <= x;
      abs_x_q  <= (x <= 0) ? $unsigned(-x) : $unsigned(x); // -32768 maps to 32768
    end
  end

  exp_neg i_exp_neg (
    .clk (clk),
    .rst (rst),
    .adv (adv),
    .a   (abs_x_q),
    .e   (e)
  );

  // sign and value ride alongside the two exp stages
  always_ff @(posedge clk) begin
    if (rst) begin
      s2_q <= '0;
      s3_q <= '0;
    end else if (adv) begin
      s2_q <= s1_q;
      s3_q <= s2_q;
    end
  end

  assign e_m1 = $signed({1'b0, e}) - $signed({1'b0, selu_pkg::EXP_ONE});

  // scale * alpha * (e - 1) lands directly in q.32
  assign prod_neg = $signed({1'b0, selu_pkg::SCALE_ALPHA_Q}) * e_m1;

  // scale * x is q.24 so move it up to q.32
  assign prod_pos = ($signed({1'b0, selu_pkg::SCALE_Q}) * s3_q.x)
                    <<< (selu_pkg::PROD_FRAC - selu_pkg::IN_FRAC - selu_pkg::CONST_FRAC);

  // product stage
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_q <= '0;
    end else if (adv) begin
      prod_q <= s3_q.neg ? prod_neg : prod_pos;
    end
  end

  fixed_round #(
    .IN_W     (selu_pkg::PROD_W),
    .IN_FRAC  (selu_pkg::PROD_FRAC),
    .OUT_W    (selu_pkg::OUT_W),
    .OUT_FRAC (selu_pkg::OUT_FRAC)
  ) i_round (
    .in  (prod_q),
    .out (y)
  );

  // a stalled sink must see the same lane result on the next edge
  a_prod_hold: assert property (@(posedge clk) disable iff (rst)
    !adv |=> $stable(prod_q));

endmodule

// File: hdl/selu_pkg.sv
package selu_pkg;

  localparam int LANES      = 4;                       // lanes per beat
  localparam int IN_W       = 16;                      // q7.8 input word
  localparam int IN_FRAC    = 8;
  localparam int OUT_W      = 19;                      // rounded result word
  localparam int OUT_FRAC   = 8;
  localparam int EXP_FRAC   = 16;                      // exp result is q1.16
  localparam int CONST_W    = 18;                      // width of the fixed multipliers
  localparam int CONST_FRAC = 16;                      // their fraction bits
  localparam int T_W        = IN_W + CONST_W;          // |x| * log2(e)
  localparam int T_FRAC     = IN_FRAC + CONST_FRAC;    // q.24
  localparam int LUT_AW     = 5;                       // table index bits
  localparam int LUT_SIZE   = 1 << LUT_AW;
  localparam int K_W        = 5;                       // holds 0..EXP_K_MAX
  localparam int EXP_K_MAX  = 17;                      // any larger shift flushes to 0
  localparam int PROD_W     = 56;                      // wide selu product
  localparam int PROD_FRAC  = 32;                      // q.32
  localparam int LATENCY    = 4;                       // accept edge to deliver edge

  localparam logic [CONST_W-1:0] LOG2E_Q       = 18'd94548;   // log2(e) in q.16
  localparam logic [CONST_W-1:0] SCALE_Q       = 18'd68859;   // selu scale
  localparam logic [CONST_W-1:0] SCALE_ALPHA_Q = 18'd115219;  // scale * alpha folded

  localparam logic [EXP_FRAC:0] EXP_ONE = 17'd65536;          // 1.0 in q1.16

  // 2^(-j/32) in q1.16
  localparam logic [EXP_FRAC:0] EXP_LUT [LUT_SIZE] = '{
    17'd65536, 17'd64132, 17'd62757, 17'd61413,
    17'd60097, 17'd58809, 17'd57549, 17'd56316,
    17'd55109, 17'd53928, 17'd52773, 17'd51642,
    17'd50535, 17'd49452, 17'd48393, 17'd47356,
    17'd46341, 17'd45348, 17'd44376, 17'd43425,
    17'd42495, 17'd41584, 17'd40693, 17'd39821,
    17'd38968, 17'd38133, 17'd37316, 17'd36516,
    17'd35734, 17'd34968, 17'd34219, 17'd33486
  };

  localparam logic [15:0] LFSR_SEED = 16'd26430;       // stimulus generator start
  localparam logic [15:0] LFSR_TAPS = 16'hB400;        // x^16 + x^14 + x^13 + x^11 + 1

  typedef logic signed [IN_W-1:0]  in_word_t;
  typedef logic signed [OUT_W-1:0] out_word_t;

  typedef struct packed {
    in_word_t [LANES-1:0] x;                           // lane i in x[i]
  } selu_in_t;

  typedef struct packed {
    out_word_t [LANES-1:0] y;
  } selu_out_t;

  typedef struct packed {
    logic     neg;                                     // x <= 0 takes the exp branch
    in_word_t x;
  } lane_stage_t;

endpackage

// File: hdl/selu_stream.sv
`timescale 1ns/10ps

module selu_stream (
  input  logic                clk,
  input  logic                rst,
  input  selu_pkg::selu_in_t  in_data,
  input  logic                in_valid,
  output logic                in_ready,
  output selu_pkg::selu_out_t out_data,
  output logic                out_valid,
  input  logic                out_ready
);

  logic                          adv;                  // whole pipeline steps together
  logic [selu_pkg::LATENCY-1:0]  vld_q;                // one bit per register stage

  assign adv      = out_ready;
  assign in_ready = out_ready;                          // straight through as in the lane datapath

  // valid tracks the data through the four lane stages
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else if (adv) begin
      vld_q <= {vld_q[selu_pkg::LATENCY-2:0], in_valid};
    end
  end

  assign out_valid = vld_q[selu_pkg::LATENCY-1];

  for (genvar i = 0; i < selu_pkg::LANES; i++) begin : g_lane
    selu_lane i_lane (
      .clk (clk),
      .rst (rst),
      .adv (adv),
      .x   (in_data.x[i]),
      .y   (out_data.y[i])
    );
  end

  a_valid_after_rst: assert property (@(posedge clk)
    rst |=> !out_valid);                               // nothing in flight after reset

  a_valid_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(out_valid));

endmodule

// File: project.f
+incdir+include
hdl/selu_pkg.sv
hdl/fixed_round.sv
hdl/exp_neg.sv
hdl/selu_lane.sv
hdl/selu_stream.sv
test/tb_selu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f \
  --top-module tb_selu \
  -Mdir obj_dir \
  -o tb_selu \
  && ./obj_dir/tb_selu \
  && echo "simulation completed" \
  || { echo "simulation did not complete cleanly" >&2; exit 1; }

// File: include/selu_model.svh
`ifndef SELU_MODEL_SVH
`define SELU_MODEL_SVH

// one lane of the datapath computed with the same table and rounding
function automatic logic signed [selu_pkg::OUT_W-1:0] selu_ref(
  input logic signed [selu_pkg::IN_W-1:0] x
);
  logic                                      neg;
  logic [selu_pkg::IN_W-1:0]                 a;
  logic [selu_pkg::T_W-1:0]                  t;
  logic [selu_pkg::T_W-selu_pkg::T_FRAC-1:0] k;
  logic [selu_pkg::LUT_AW-1:0]               j;
  logic [selu_pkg::EXP_FRAC:0]               e;
  longint                                    p;        // q.32 product
  longint                                    r;
  longint                                    r_max;
  neg = (x <= 0);
  a = neg ? $unsigned(-x) : $unsigned(x);
  t = a * selu_pkg::LOG2E_Q;
  k = t[selu_pkg::T_W-1:selu_pkg::T_FRAC];
  j = t[selu_pkg::T_FRAC-1 -: selu_pkg::LUT_AW];
  if (k >= selu_pkg::EXP_K_MAX) begin
    e = '0;
  end else begin
    e = selu_pkg::EXP_LUT[j] >> k;
  end
  if (neg) begin
    p = longint'(selu_pkg::SCALE_ALPHA_Q) * (longint'(e) - longint'(selu_pkg::EXP_ONE));
  end else begin
    p = longint'(selu_pkg::SCALE_Q) * longint'(x)
        * (longint'(1) <<< (selu_pkg::PROD_FRAC - selu_pkg::IN_FRAC - selu_pkg::CONST_FRAC));
  end
  r = (p + (longint'(1) <<< (selu_pkg::PROD_FRAC - selu_pkg::OUT_FRAC - 1)))
      >>> (selu_pkg::PROD_FRAC - selu_pkg::OUT_FRAC); // round half up
  r_max = (longint'(1) <<< (selu_pkg::OUT_W - 1)) - 1;
  if (r > r_max) begin
    r = r_max;
  end else if (r < -r_max - 1) begin
    r = -r_max - 1;
  end
  return selu_pkg::OUT_W'(r);
endfunction

// one step of the 16-bit galois lfsr
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ selu_pkg::LFSR_TAPS;                       // feedback on the shifted-out bit
  end
  return n;
endfunction

`endif

// File: test/tb_selu.sv
`timescale 1ns/10ps

module tb_selu;

  `include "selu_model.svh"

  typedef struct packed {
    selu_pkg::selu_out_t y;                            // expected lanes
    logic [31:0]         adv_at;                       // advancing edge of the accept
  } exp_beat_t;

  logic                clk;
  logic                rst;
  selu_pkg::selu_in_t  in_data;
  logic                in_valid;
  logic                in_ready;
  selu_pkg::selu_out_t out_data;
  logic                out_valid;
  logic                out_ready;

  exp_beat_t           exp_q [$];                      // scoreboard, oldest first
  exp_beat_t           beat;
  selu_pkg::selu_in_t  stim;
  selu_pkg::selu_out_t last_data;                      // outputs seen at the previous edge
  logic                last_valid;
  logic                held_q;                         // previous edge was a stall
  logic                bp_on;                          // random back-pressure enable
  logic [15:0]         data_lfsr;
  logic [15:0]         bp_lfsr;
  logic [31:0]         rnd;
  logic [1:0]          bp_bits;
  int unsigned         acc_cnt;
  int unsigned         adv_cnt;                        // edges where the pipeline moved
  int unsigned         cyc_cnt;
  int unsigned         cycle_limit;
  int unsigned         wait_cyc;
  int                  n_random;
  int                  n_bp;

  selu_stream i_selu_stream (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #4 clk = ~clk;                                // 8 ns period

  task automatic abort_run(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic check_val(input string name, input longint got, input longint exp_v);
    if (got != exp_v) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp_v);
      abort_run("value check failed");
    end
  endtask

  // one lfsr step per bit taken and msb first
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      data_lfsr = lfsr_step(data_lfsr);
      v = {v[30:0], data_lfsr[0]};
    end
  endtask

  task automatic make_random_beat(output selu_pkg::selu_in_t d);
    logic [31:0] v;
    for (int i = 0; i < selu_pkg::LANES; i++) begin
      take_bits(16, v);
      d.x[i] = v[15:0];                                // full range, both signs
    end
  endtask

  // present a beat and hold it until the DUT takes it
  task automatic send_beat(input selu_pkg::selu_in_t d);
    in_data  <= d;
    in_valid <= 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    in_valid <= 1'b0;                                  // overridden by a back-to-back send
  endtask

  always @(posedge clk) begin                          // sink ready is random while bp_on
    if (bp_on) begin
      bp_lfsr    = lfsr_step(bp_lfsr);
      bp_bits[0] = bp_lfsr[0];
      bp_lfsr    = lfsr_step(bp_lfsr);
      bp_bits[1] = bp_lfsr[0];
      out_ready <= (bp_bits != 2'b00);                 // stall about one edge in four
    end else begin
      out_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin                          // scoreboard and protocol checks
    if (!rst) begin
      check_val("in_ready", in_ready, out_ready);
      if (acc_cnt == 0) begin
        check_val("out_valid", out_valid, 0);          // nothing accepted yet
      end
      if (held_q) begin
        check_val("out_valid held", out_valid, last_valid);
        for (int i = 0; i < selu_pkg::LANES; i++) begin
          check_val($sformatf("out_data.y[%0d] held", i), out_data.y[i], last_data.y[i]);
        end
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a beat was delivered with no beat in flight");
        end else begin
          beat = exp_q.pop_front();
          check_val("latency", adv_cnt - beat.adv_at, selu_pkg::LATENCY);
          for (int i = 0; i < selu_pkg::LANES; i++) begin
            check_val($sformatf("out_data.y[%0d]", i), out_data.y[i], beat.y.y[i]);
          end
        end
      end
      if (in_valid && in_ready) begin
        for (int i = 0; i < selu_pkg::LANES; i++) begin
          beat.y.y[i] = selu_ref(in_data.x[i]);
        end
        beat.adv_at = adv_cnt;
        exp_q.push_back(beat);
        acc_cnt++;
      end
      if (out_ready) begin
        adv_cnt++;
      end
      held_q     = !out_ready;                         // no advance on this edge
      last_valid = out_valid;
      last_data  = out_data;
    end
  end

  always @(posedge clk) begin                          // run limit
    cyc_cnt++;
    if (cyc_cnt >= cycle_limit) begin
      abort_run("timeout: the run exceeded its cycle limit");
    end
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    in_data    = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    bp_on      = 1'b0;
    held_q     = 1'b0;
    last_valid = 1'b0;
    last_data  = '0;
    data_lfsr  = selu_pkg::LFSR_SEED;
    bp_lfsr    = selu_pkg::LFSR_SEED;
    acc_cnt    = 0;
    adv_cnt    = 0;
    cyc_cnt    = 0;
    n_random   = 1000;
    n_bp       = 100;
    cycle_limit = 4 * (n_random + n_bp) + 600;         // about 4x the expected run
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);                         // idle, out_valid must stay low
    // reference spot values from the fixed-point rules
    check_val("ref x=0", selu_ref(16'sd0), 0);
    check_val("ref x=1.0", selu_ref(16'sd256), (selu_pkg::SCALE_Q + 128) >> 8);
    check_val("ref x=min", selu_ref(-16'sd32768),
              (-longint'(selu_pkg::SCALE_ALPHA_Q) + 128) >>> 8);
    stim.x[0] = 16'sd0;                                // zero
    stim.x[1] = 16'sd256;                              // one
    stim.x[2] = -16'sd32768;                           // both extremes
    stim.x[3] = 16'sd32767;
    send_beat(stim);
    stim.x[0] = -16'sd1;                               // around one lsb
    stim.x[1] = -16'sd2;
    stim.x[2] = 16'sd1;
    stim.x[3] = -16'sd256;
    send_beat(stim);
    repeat (6) @(posedge clk);
    make_random_beat(stim);
    send_beat(stim);                                   // isolated beat, latency check
    repeat (6) @(posedge clk);
    for (int n = 0; n < n_random; n++) begin
      make_random_beat(stim);
      send_beat(stim);
    end
    bp_on <= 1'b1;
    for (int n = 0; n < n_bp; n++) begin
      take_bits(1, rnd);
      if (!rnd[0]) begin
        @(posedge clk);                                // gap on the source side
      end
      make_random_beat(stim);
      send_beat(stim);
    end
    bp_on <= 1'b0;
    wait_cyc = 0;
    while (exp_q.size() != 0 && wait_cyc < 64) begin
      @(posedge clk);
      wait_cyc++;
    end
    repeat (8) @(posedge clk);                         // a stray beat would hit the empty queue
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected beats were never delivered", exp_q.size()));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule
